//--- all.f
src/lc3b_pkg.sv
src/mem_access_ctrl.sv
src/stage_mem.sv
src/perf_counters.sv
src/data_memory.sv
src/mem_subsystem.sv
testbench/mem_checker.sv
testbench/tb_mem.sv

//--- src/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int mem_wait = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         cyc,
    input  logic         stb,
    input  logic         we,
    input  logic [11:0]  adr,
    input  logic [15:0]  sel,
    input  logic [127:0] dat_m,
    output logic [127:0] dat_s,
    output logic         ack
);

    localparam int cnt_w = $clog2(mem_wait + 1) + 1;

    logic [127:0]     mem [64];
    logic [cnt_w-1:0] wait_cnt;
    logic [5:0]       line;
    logic             request;
    logic             serve;

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
    end

    assign line    = adr[5:0];                  // upper lines alias.
    assign request = cyc && stb && !ack;
    assign serve   = request && !rst && wait_cnt == cnt_w'(mem_wait);

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            ack      <= 1'b0;
        end else begin
            ack <= serve;
            if (request && !serve) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            if (we) begin
                for (int i = 0; i < 16; i++) begin
                    if (sel[i]) begin
                        mem[line][i*8 +: 8] <= dat_m[i*8 +: 8];
                    end
                end
            end else begin
                dat_s <= mem[line];             // valid in the ack cycle.
            end
        end
    end

endmodule

//--- src/lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_cc;                 // n, z, p.
    typedef logic [1:0]  lc3b_cc_mux_sel;
    typedef logic [1:0]  lc3b_regfile_mux_sel;
    typedef logic [1:0]  lc3b_addr_mux_sel;

    ////////////////////////////////////////////////////////////////////////////
    // mux select codes
    ////////////////////////////////////////////////////////////////////////////

    localparam lc3b_cc_mux_sel cc_from_pcn = 2'd0;
    localparam lc3b_cc_mux_sel cc_from_alu = 2'd1;
    localparam lc3b_cc_mux_sel cc_from_mdr = 2'd2;
    localparam lc3b_cc_mux_sel cc_from_sr2 = 2'd3;

    localparam lc3b_regfile_mux_sel rf_from_pc  = 2'd0;
    localparam lc3b_regfile_mux_sel rf_from_pcn = 2'd1;
    localparam lc3b_regfile_mux_sel rf_from_alu = 2'd3;    // 2 left open.

    localparam lc3b_addr_mux_sel addr_from_trap = 2'd0;
    localparam lc3b_addr_mux_sel addr_from_alu  = 2'd1;
    localparam lc3b_addr_mux_sel addr_from_mdr  = 2'd2;

    ////////////////////////////////////////////////////////////////////////////
    // memory stage control word
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        lc3b_cc_mux_sel      cc_mux_sel;
        logic                cc_load;
        logic                br_en_load;
        logic                mem_access;              // low for non-memory ops.
        logic                mem_write;
        logic                word_align;              // low selects a byte.
        logic                indirect;                // ldi and sti.
        logic                trap;
        lc3b_regfile_mux_sel regfile_mux_sel;
    } lc3b_ctrl_word;

    ////////////////////////////////////////////////////////////////////////////
    // performance counter indices
    ////////////////////////////////////////////////////////////////////////////

    localparam int ctr_loads    = 0;
    localparam int ctr_stores   = 1;
    localparam int ctr_taken    = 2;
    localparam int ctr_stall    = 3;
    localparam int num_counters = 4;

endpackage

//--- src/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  lc3b_pkg::lc3b_ctrl_word    ctrl,
    input  logic                       ack,
    input  logic                       cancel,
    output lc3b_pkg::lc3b_addr_mux_sel addr_sel,
    output logic                       mem_we,
    output logic                       mdr_load,
    output logic                       request_stall,
    output logic                       access_done
);
    import lc3b_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_pointer,
        st_final
    } state_t;

    state_t state;
    state_t state_next;
    state_t phase;
    logic   phase_done;
    logic   advance;

    // a new access starts its first phase straight from idle.
    always_comb begin
        if (state == st_idle) begin
            phase = ctrl.indirect ? st_pointer : st_final;
        end else begin
            phase = state;
        end
    end

    assign phase_done = ctrl.mem_access && (ack || cancel);
    assign advance    = phase_done && !stall;   // repeat if the pipe is held.

    always_comb begin
        addr_sel = addr_from_alu;
        mem_we   = 1'b0;
        mdr_load = 1'b0;
        case (phase)
            st_pointer: begin
                mdr_load = phase_done;          // pointer into internal mdr.
            end
            st_final: begin
                mem_we = ctrl.mem_write;
                if (ctrl.indirect) begin
                    addr_sel = addr_from_mdr;
                end else if (ctrl.trap) begin
                    addr_sel = addr_from_trap;
                end
            end
            default: ;
        endcase
    end

    assign request_stall = ctrl.mem_access && !(phase == st_final && ack);
    assign access_done   = advance && phase == st_final;

    always_comb begin
        if (!ctrl.mem_access) begin
            state_next = st_idle;
        end else if (advance) begin
            state_next = (phase == st_pointer) ? st_final : st_idle;
        end else begin
            state_next = phase;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- src/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter lc3b_pkg::lc3b_word counter_base = 16'hff00,
    parameter int                 mem_wait     = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  lc3b_pkg::lc3b_ctrl_word ctrl,
    input  lc3b_pkg::lc3b_word      alu,
    input  lc3b_pkg::lc3b_word      ir,
    input  lc3b_pkg::lc3b_word      pc,
    input  lc3b_pkg::lc3b_word      pcn,
    input  lc3b_pkg::lc3b_word      sr2,
    output logic                    br_en,
    output lc3b_pkg::lc3b_word      mdr,
    output lc3b_pkg::lc3b_word      regfile_data,
    output logic                    mem_stall_req
);
    import lc3b_pkg::*;

    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic         wb_ack;
    logic [11:0]  wb_adr;
    logic [15:0]  wb_sel;
    logic [127:0] wb_dat_m;
    logic [127:0] wb_dat_s;
    logic         cancel;
    lc3b_word     ctr_data;
    lc3b_word     mem_addr;
    logic         access_done;
    logic         taken;

    stage_mem u_stage (
        .clk, .rst, .stall, .ctrl, .alu, .ir, .pc, .pcn, .sr2,
        .wb_ack, .wb_dat_s, .cancel, .ctr_data,
        .br_en, .mdr, .regfile_data, .mem_stall_req,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_m,
        .mem_addr, .access_done, .taken
    );

    perf_counters #(.counter_base(counter_base)) u_counters (
        .clk, .rst, .addr(mem_addr), .wdata(sr2),
        .mem_access(ctrl.mem_access), .mem_write(ctrl.mem_write),
        .access_done, .taken, .stall_cycle(mem_stall_req),
        .cancel, .ctr_data
    );

    data_memory #(.mem_wait(mem_wait)) u_memory (
        .clk, .rst, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .sel(wb_sel), .dat_m(wb_dat_m), .dat_s(wb_dat_s), .ack(wb_ack)
    );

endmodule

//--- src/perf_counters.sv
`timescale 1ns/1ps

module perf_counters #(
    parameter lc3b_pkg::lc3b_word counter_base = 16'hff00
) (
    input  logic               clk,
    input  logic               rst,
    input  lc3b_pkg::lc3b_word addr,
    input  lc3b_pkg::lc3b_word wdata,
    input  logic               mem_access,
    input  logic               mem_write,
    input  logic               access_done,
    input  logic               taken,
    input  logic               stall_cycle,
    output logic               cancel,
    output lc3b_pkg::lc3b_word ctr_data
);
    import lc3b_pkg::*;

    localparam int idx_w = $clog2(num_counters);

    lc3b_word         counters [num_counters];
    lc3b_word         offset;
    logic [idx_w-1:0] idx;
    logic             in_window;
    logic             load_done;
    logic             store_done;
    logic             ctr_clear;

    assign in_window = addr >= counter_base;
    assign cancel    = mem_access && in_window;
    assign offset    = addr - counter_base;
    assign idx       = offset[idx_w:1];         // one counter per word.
    assign ctr_data  = counters[idx];

    // window accesses are not counted themselves.
    assign load_done  = access_done && !cancel && !mem_write;
    assign store_done = access_done && !cancel && mem_write;

    // any store into the window clears, whatever wdata holds.
    assign ctr_clear = access_done && cancel && mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_counters; i++) begin
                counters[i] <= '0;
            end
        end else begin
            if (load_done) begin
                counters[ctr_loads] <= counters[ctr_loads] + 1'b1;
            end
            if (store_done) begin
                counters[ctr_stores] <= counters[ctr_stores] + 1'b1;
            end
            if (taken) begin
                counters[ctr_taken] <= counters[ctr_taken] + 1'b1;
            end
            if (stall_cycle) begin
                counters[ctr_stall] <= counters[ctr_stall] + 1'b1;
            end
            if (ctr_clear) begin
                counters[idx] <= '0;            // clear wins over a count.
            end
        end
    end

endmodule

//--- src/stage_mem.sv
`timescale 1ns/1ps

module stage_mem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  lc3b_pkg::lc3b_ctrl_word ctrl,
    input  lc3b_pkg::lc3b_word      alu,
    input  lc3b_pkg::lc3b_word      ir,
    input  lc3b_pkg::lc3b_word      pc,
    input  lc3b_pkg::lc3b_word      pcn,
    input  lc3b_pkg::lc3b_word      sr2,
    input  logic                    wb_ack,
    input  logic [127:0]            wb_dat_s,
    input  logic                    cancel,
    input  lc3b_pkg::lc3b_word      ctr_data,
    output logic                    br_en,
    output lc3b_pkg::lc3b_word      mdr,
    output lc3b_pkg::lc3b_word      regfile_data,
    output logic                    mem_stall_req,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [11:0]             wb_adr,
    output logic [15:0]             wb_sel,
    output logic [127:0]            wb_dat_m,
    output lc3b_pkg::lc3b_word      mem_addr,
    output logic                    access_done,
    output logic                    taken
);
    import lc3b_pkg::*;

    lc3b_addr_mux_sel addr_sel;
    logic             mem_we;
    logic             mdr_load;
    logic             request_stall;
    lc3b_word         trapvect8;
    lc3b_word         internal_mdr;
    logic [2:0]       word_lane;
    logic [3:0]       byte_lane;
    lc3b_word         cc_src;
    lc3b_cc           cc_next;
    lc3b_cc           cc;
    logic             br_en_next;

    mem_access_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .ctrl          (ctrl),
        .ack           (wb_ack),
        .cancel        (cancel),
        .addr_sel      (addr_sel),
        .mem_we        (mem_we),
        .mdr_load      (mdr_load),
        .request_stall (request_stall),
        .access_done   (access_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // address and bus lanes
    ////////////////////////////////////////////////////////////////////////////

    assign trapvect8 = {7'b0, ir[7:0], 1'b0};

    always_comb begin
        case (addr_sel)
            addr_from_trap: mem_addr = trapvect8;
            addr_from_mdr:  mem_addr = internal_mdr;
            default:        mem_addr = alu;
        endcase
    end

    assign word_lane = mem_addr[3:1];
    assign byte_lane = mem_addr[3:0];           // odd address is the high lane.

    assign wb_cyc = ctrl.mem_access && !cancel;
    assign wb_stb = ctrl.mem_access && !cancel;
    assign wb_we  = mem_we;
    assign wb_adr = mem_addr[15:4];

    always_comb begin
        wb_sel   = '0;
        wb_dat_m = '0;
        if (ctrl.word_align) begin
            wb_sel[word_lane*2 +: 2]     = 2'b11;
            wb_dat_m[word_lane*16 +: 16] = sr2;
        end else begin
            wb_sel[byte_lane]           = 1'b1;
            wb_dat_m[byte_lane*8 +: 8]  = sr2[7:0];
        end
    end

    always_comb begin
        if (cancel) begin
            mdr = ctr_data;                     // counter window read.
        end else if (ctrl.word_align) begin
            mdr = wb_dat_s[word_lane*16 +: 16];
        end else begin
            mdr = {8'h00, wb_dat_s[byte_lane*8 +: 8]};
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_load && !stall) begin
            internal_mdr <= mdr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // condition codes and branch enable
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.cc_mux_sel)
            cc_from_pcn: cc_src = pcn;
            cc_from_alu: cc_src = alu;
            cc_from_mdr: cc_src = mdr;
            cc_from_sr2: cc_src = sr2;
        endcase
    end

    assign cc_next    = {cc_src[15], cc_src == '0, !cc_src[15] && cc_src != '0};
    assign br_en_next = |(cc & ir[11:9]);       // uses cc before this edge.

    always_ff @(posedge clk) begin
        if (rst) begin
            cc    <= '0;
            br_en <= 1'b0;
        end else if (!stall) begin
            if (ctrl.cc_load) begin
                cc <= cc_next;
            end
            if (ctrl.br_en_load) begin
                br_en <= br_en_next;
            end
        end
    end

    assign taken = ctrl.br_en_load && !stall && br_en_next;

    ////////////////////////////////////////////////////////////////////////////
    // forwarding and stall
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.regfile_mux_sel)
            rf_from_pc:  regfile_data = pc;
            rf_from_pcn: regfile_data = pcn;
            rf_from_alu: regfile_data = alu;
            default:     regfile_data = '0;
        endcase
    end

    assign mem_stall_req = request_stall && !cancel;

endmodule

//--- testbench/mem_checker.sv
`timescale 1ns/1ps

module mem_checker (
    input  logic               clk,
    input  logic               strobe,
    input  logic               check_mdr,
    input  logic               window,
    input  int                 stall_cycles,
    input  lc3b_pkg::lc3b_word exp_mdr,
    input  logic               exp_br_en,
    input  lc3b_pkg::lc3b_word exp_rf,
    input  logic               br_en,
    input  lc3b_pkg::lc3b_word mdr,
    input  lc3b_pkg::lc3b_word regfile_data,
    output int                 error_count
);

    initial error_count = 0;

    // compared at the edge that closes the instruction.
    always @(posedge clk) begin
        if (strobe) begin
            if (check_mdr && mdr !== exp_mdr) begin
                $display("[FAIL] %0t: mdr is %h, expected %h", $time, mdr, exp_mdr);
                error_count++;
            end
            if (br_en !== exp_br_en) begin
                $display("[FAIL] %0t: br_en is %b, expected %b", $time, br_en, exp_br_en);
                error_count++;
            end
            if (regfile_data !== exp_rf) begin
                $display("[FAIL] %0t: regfile_data is %h, expected %h",
                         $time, regfile_data, exp_rf);
                error_count++;
            end
            if (window && stall_cycles != 0) begin  // counter reads never stall.
                $display("[FAIL] %0t: counter access stalled for %0d cycles, expected 0",
                         $time, stall_cycles);
                error_count++;
            end
        end
    end

endmodule

//--- testbench/mem_input.txt
# cc_sel cc_ld br_ld access write word indirect trap rf_sel alu ir pc pcn sr2 mdr br_en rf
# all hex; br_en is the value held while the line is in the stage
1 0 0 1 1 1 0 0 3 0040 0000 3000 3002 1234 0000 0 0040
1 0 0 1 1 1 0 0 0 0042 0000 3002 3004 abcd 0000 0 3002
1 0 0 1 0 1 0 0 1 0040 0000 3004 3006 0000 1234 0 3006
1 0 0 1 0 1 0 0 3 0042 0000 3006 3008 0000 abcd 0 0042
1 0 0 1 0 1 0 0 3 0044 0000 3008 300a 0000 0000 0 0044
1 0 0 1 1 0 0 0 3 0043 0000 300a 300c 5a77 0000 0 0043
1 0 0 1 0 0 0 0 3 0043 0000 300c 300e 0000 0077 0 0043
1 0 0 1 0 0 0 0 3 0042 0000 300e 3010 0000 00cd 0 0042
1 0 0 1 0 1 0 0 3 0042 0000 3010 3012 0000 77cd 0 0042
1 0 0 1 1 1 0 0 3 0050 0000 3012 3014 0060 0000 0 0050
1 0 0 1 1 1 0 0 3 0060 0000 3014 3016 beef 0000 0 0060
1 0 0 1 0 1 1 0 3 0050 0000 3016 3018 0000 beef 0 0050
1 0 0 1 1 1 1 0 3 0050 0000 3018 301a cafe 0000 0 0050
1 0 0 1 0 1 0 0 3 0060 0000 301a 301c 0000 cafe 0 0060
1 0 0 1 0 1 0 1 0 1111 0021 301c 301e 0000 77cd 0 301c
1 1 0 0 0 0 0 0 3 8000 0000 301e 3020 0000 0000 0 8000
1 1 1 0 0 0 0 0 3 0000 0800 3020 3022 0000 0000 0 0000
1 1 1 0 0 0 0 0 3 0005 0400 3022 3024 0000 0000 1 0005
3 1 1 0 0 0 0 0 3 0007 0200 3024 3026 ff00 0000 1 0007
1 0 1 0 0 0 0 0 3 0009 0600 3026 3028 0000 0000 1 0009
2 1 0 1 0 1 0 0 3 0040 0000 3028 302a 0000 1234 0 0040
1 0 1 0 0 0 0 0 1 000b 0200 302a 302c 0000 0000 0 302c
1 0 0 1 0 1 0 0 3 ff00 0000 302c 302e 0000 000a 1 ff00
1 0 0 1 0 1 0 0 3 ff02 0000 302e 3030 0000 0006 1 ff02
1 0 0 1 1 1 0 0 3 ff00 0000 3030 3032 1234 0000 1 ff00
1 0 0 1 0 1 0 0 3 ff00 0000 3032 3034 0000 0000 1 ff00

//--- testbench/tb_mem.sv
`timescale 1ns/1ps

module tb_mem;
    import lc3b_pkg::*;

    localparam lc3b_word counter_base = 16'hff00;
    localparam int       mem_wait     = 2;
    localparam int       timeout      = 200;

    logic          clk;
    logic          rst;
    logic          stall;
    lc3b_ctrl_word ctrl;
    lc3b_word      alu;
    lc3b_word      ir;
    lc3b_word      pc;
    lc3b_word      pcn;
    lc3b_word      sr2;
    logic          br_en;
    lc3b_word      mdr;
    lc3b_word      regfile_data;
    logic          mem_stall_req;
    logic          strobe;
    logic          check_mdr;
    logic          window;
    int            stall_cycles;
    lc3b_word      exp_mdr;
    logic          exp_br_en;
    lc3b_word      exp_rf;
    int            error_count;
    int            file_errors;
    int            timeouts;

    mem_subsystem #(.counter_base(counter_base), .mem_wait(mem_wait)) u_dut (
        .clk, .rst, .stall, .ctrl, .alu, .ir, .pc, .pcn, .sr2,
        .br_en, .mdr, .regfile_data, .mem_stall_req
    );

    mem_checker u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // looks at the stall request half a cycle ahead of each edge.
    task automatic wait_for_release(output logic ok);
        ok           = 1'b0;
        stall_cycles = 0;
        while (!ok && stall_cycles < timeout) begin
            @(negedge clk);
            if (mem_stall_req) begin
                stall_cycles++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus from file
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int       fd;
        int       n;
        logic     ok;
        string    line;
        lc3b_word f [17];

        rst          = 1'b1;
        stall        = 1'b0;
        ctrl         = '0;
        alu          = '0;
        ir           = '0;
        pc           = '0;
        pcn          = '0;
        sr2          = '0;
        strobe       = 1'b0;
        check_mdr    = 1'b0;
        window       = 1'b0;
        stall_cycles = 0;
        exp_mdr      = '0;
        exp_br_en    = 1'b0;
        exp_rf       = '0;
        file_errors  = 0;
        timeouts     = 0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        fd = $fopen("testbench/mem_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/mem_input.txt");
            file_errors++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
            if (n != 17) begin
                $display("stimulus line has %0d fields instead of 17: %s", n, line);
                file_errors++;
                continue;
            end
            @(posedge clk);
            #1;
            strobe    = 1'b0;
            ctrl      = {f[0][1:0], f[1][0], f[2][0], f[3][0], f[4][0], f[5][0],
                         f[6][0], f[7][0], f[8][1:0]};
            alu       = f[9];
            ir        = f[10];
            pc        = f[11];
            pcn       = f[12];
            sr2       = f[13];
            exp_mdr   = f[14];
            exp_br_en = f[15][0];
            exp_rf    = f[16];
            check_mdr = ctrl.mem_access && !ctrl.mem_write;    // mdr only on loads.
            window    = ctrl.mem_access && !ctrl.indirect && !ctrl.trap
                        && alu >= counter_base;
            wait_for_release(ok);
            if (!ok) begin
                $display("timeout: mem_stall_req stayed high for %0d cycles", timeout);
                timeouts++;
                break;
            end
            strobe = 1'b1;
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(posedge clk);
        #1;
        strobe = 1'b0;
        ctrl   = '0;
        repeat (2) @(posedge clk);
        $display("done: %0d check errors, %0d file errors, %0d timeouts",
                 error_count, file_errors, timeouts);
        if (error_count == 0 && file_errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
